//--- include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus word and strobe widths
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// internal memory word address, 4096 words
`define SOC_MEM_AW 12

// data bus word address, top bit selects the peripheral
`define SOC_D_AW 13

// timer register word offsets, from the low address bits
`define SOC_TMR_AW 2
`define SOC_TMR_CTRL 2'd0
`define SOC_TMR_LOAD 2'd1
`define SOC_TMR_COUNT 2'd2

`endif

//--- logic/soc_mem_pkg.sv
`default_nettype none

`include "soc_settings.svh"

package soc_mem_pkg;

   // one bus word and its byte strobes
   typedef logic [`SOC_DATA_W-1:0] data_t;
   typedef logic [`SOC_STRB_W-1:0] strb_t;

   // internal memory / instruction bus word address
   typedef logic [`SOC_MEM_AW-1:0] mem_addr_t;

   // data bus word address, memory plus peripheral window
   typedef logic [`SOC_D_AW-1:0] d_addr_t;

   // timer register select
   typedef enum logic [1:0] {
      tmr_ctrl,
      tmr_load,
      tmr_count,
      tmr_none
   } tmr_reg_e;

endpackage

`default_nettype wire

//--- logic/soc_ram_dp_be.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_ram_dp_be
   import soc_mem_pkg::*;
(
   input  wire       clk_i,

   // port A, data side, byte writes
   input  wire       a_en_i,
   input  mem_addr_t a_addr_i,
   input  strb_t     a_we_i,
   input  data_t     a_d_i,
   output data_t     a_d_o,

   // port B, instruction side, read only
   input  wire       b_en_i,
   input  mem_addr_t b_addr_i,
   output data_t     b_d_o
);

   localparam int unsigned depth = 1 << `SOC_MEM_AW;

   data_t mem [0:depth-1];

   // port A is read-first, the output register sees the old word
   always_ff @(posedge clk_i) begin
      if (a_en_i) begin
         a_d_o <= mem[a_addr_i];
      end
   end

   // byte lanes written independently
   always_ff @(posedge clk_i) begin
      if (a_en_i) begin
         for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (a_we_i[b]) begin
               mem[a_addr_i][8*b +: 8] <= a_d_i[8*b +: 8];
            end
         end
      end
   end

   // port B read register
   // a same-cycle write on A to this word is not seen until the next read
   always_ff @(posedge clk_i) begin
      if (b_en_i) begin
         b_d_o <= mem[b_addr_i];
      end
   end

endmodule

`default_nettype wire

//--- logic/soc_int_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_int_mem
   import soc_mem_pkg::*;
(
   input  wire       clk_i,
   input  wire       rst_i,

   // instruction bus
   input  wire       i_avalid_i,
   input  mem_addr_t i_addr_i,
   output data_t     i_rdata_o,
   output logic      i_rvalid_o,
   output wire       i_ready_o,

   // data bus
   input  wire       d_avalid_i,
   input  mem_addr_t d_addr_i,
   input  data_t     d_wdata_i,
   input  strb_t     d_wstrb_i,
   output data_t     d_rdata_o,
   output logic      d_rvalid_o,
   output wire       d_ready_o
);

   // the RAM never stalls
   assign i_ready_o = 1'b1;
   assign d_ready_o = 1'b1;

   // every instruction request is a read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         i_rvalid_o <= 1'b0;
      end else begin
         i_rvalid_o <= i_avalid_i;
      end
   end

   // data request with no strobes is a read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         d_rvalid_o <= 1'b0;
      end else begin
         d_rvalid_o <= d_avalid_i & ~(|d_wstrb_i);
      end
   end

   // data bus on port A, instruction bus on port B
   soc_ram_dp_be u_ram (
      .clk_i    (clk_i),
      .a_en_i   (d_avalid_i),
      .a_addr_i (d_addr_i),
      .a_we_i   (d_wstrb_i),
      .a_d_i    (d_wdata_i),
      .a_d_o    (d_rdata_o),
      .b_en_i   (i_avalid_i),
      .b_addr_i (i_addr_i),
      .b_d_o    (i_rdata_o)
   );

endmodule

`default_nettype wire

//--- logic/soc_data_split.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_data_split
   import soc_mem_pkg::*;
(
   input  wire     clk_i,
   input  wire     rst_i,

   // data bus request
   input  wire     d_avalid_i,
   input  d_addr_t d_addr_i,

   // returns from the two targets
   input  data_t   mem_rdata_i,
   input  wire     mem_rvalid_i,
   input  data_t   tmr_rdata_i,
   input  wire     tmr_rvalid_i,

   // steered strobes and the merged response
   output wire     mem_avalid_o,
   output wire     tmr_avalid_o,
   output data_t   d_rdata_o,
   output wire     d_rvalid_o
);

   logic sel_tmr;
   logic sel_tmr_q;

   // top word-address bit picks the peripheral window
   assign sel_tmr = d_addr_i[`SOC_D_AW-1];

   assign mem_avalid_o = d_avalid_i & ~sel_tmr;
   assign tmr_avalid_o = d_avalid_i & sel_tmr;

   // target of the request now in flight
   // only updated on a request, so an idle cycle keeps the last choice
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_tmr_q <= 1'b0;
      end else if (d_avalid_i) begin
         sel_tmr_q <= sel_tmr;
      end
   end

   // response mux, both targets answer one cycle after the request
   assign d_rdata_o  = sel_tmr_q ? tmr_rdata_i : mem_rdata_i;
   assign d_rvalid_o = sel_tmr_q ? tmr_rvalid_i : mem_rvalid_i;

endmodule

`default_nettype wire

//--- logic/soc_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_timer
   import soc_mem_pkg::*;
(
   input  wire                   clk_i,
   input  wire                   rst_i,

   // register access
   input  wire                   avalid_i,
   input  wire [`SOC_TMR_AW-1:0] addr_i,
   input  data_t                 wdata_i,
   input  strb_t                 wstrb_i,
   output data_t                 rdata_o,
   output logic                  rvalid_o
);

   tmr_reg_e sel;
   logic     wr_en;
   logic     rd_en;
   logic     load_cmd;
   logic     en_q;
   data_t    load_q;
   data_t    count_q;
   data_t    rd_val;

   // offset decode
   always_comb begin
      case (addr_i)
         `SOC_TMR_CTRL:  sel = tmr_ctrl;
         `SOC_TMR_LOAD:  sel = tmr_load;
         `SOC_TMR_COUNT: sel = tmr_count;
         default:        sel = tmr_none;
      endcase
   end

   assign wr_en = avalid_i & (|wstrb_i);
   assign rd_en = avalid_i & ~(|wstrb_i);

   // ctrl bits live in byte 0
   // bit 1 is a one-shot copy of load into count, not stored
   assign load_cmd = wr_en & (sel == tmr_ctrl) & wstrb_i[0] & wdata_i[1];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         en_q <= 1'b0;
      end else if (wr_en && sel == tmr_ctrl && wstrb_i[0]) begin
         en_q <= wdata_i[0];
      end
   end

   // load register, byte strobed
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         load_q <= '0;
      end else if (wr_en && sel == tmr_load) begin
         for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (wstrb_i[b]) begin
               load_q[8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   // copy has priority over the increment
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (load_cmd) begin
         count_q <= load_q;
      end else if (en_q) begin
         count_q <= count_q + 1'b1;
      end
   end

   // read mux, unused offset reads as zero
   always_comb begin
      case (sel)
         tmr_ctrl:  rd_val = {{(`SOC_DATA_W-1){1'b0}}, en_q};
         tmr_load:  rd_val = load_q;
         tmr_count: rd_val = count_q;
         default:   rd_val = '0;
      endcase
   end

   // count sampled in the cycle the read is accepted
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_o <= rd_val;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= rd_en;
      end
   end

endmodule

`default_nettype wire

//--- logic/soc_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_mem_subsys
   import soc_mem_pkg::*;
(
   input  wire       clk_i,
   input  wire       rst_i,

   // instruction bus, read only
   input  wire       i_avalid_i,
   input  mem_addr_t i_addr_i,
   output data_t     i_rdata_o,
   output wire       i_rvalid_o,
   output wire       i_ready_o,

   // data bus
   input  wire       d_avalid_i,
   input  d_addr_t   d_addr_i,
   input  data_t     d_wdata_i,
   input  strb_t     d_wstrb_i,
   output data_t     d_rdata_o,
   output wire       d_rvalid_o,
   output wire       d_ready_o
);

   // split to target strobes
   wire   mem_avalid;
   wire   tmr_avalid;

   // target responses back to the split
   data_t mem_rdata;
   wire   mem_rvalid;
   data_t tmr_rdata;
   wire   tmr_rvalid;

   soc_data_split u_split (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .d_avalid_i   (d_avalid_i),
      .d_addr_i     (d_addr_i),
      .mem_rdata_i  (mem_rdata),
      .mem_rvalid_i (mem_rvalid),
      .tmr_rdata_i  (tmr_rdata),
      .tmr_rvalid_i (tmr_rvalid),
      .mem_avalid_o (mem_avalid),
      .tmr_avalid_o (tmr_avalid),
      .d_rdata_o    (d_rdata_o),
      .d_rvalid_o   (d_rvalid_o)
   );

   // data bus ready is the memory's own ready level
   soc_int_mem u_int_mem (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .i_avalid_i (i_avalid_i),
      .i_addr_i   (i_addr_i),
      .i_rdata_o  (i_rdata_o),
      .i_rvalid_o (i_rvalid_o),
      .i_ready_o  (i_ready_o),
      .d_avalid_i (mem_avalid),
      .d_addr_i   (d_addr_i[`SOC_MEM_AW-1:0]),
      .d_wdata_i  (d_wdata_i),
      .d_wstrb_i  (d_wstrb_i),
      .d_rdata_o  (mem_rdata),
      .d_rvalid_o (mem_rvalid),
      .d_ready_o  (d_ready_o)
   );

   // timer sees only the low offset bits
   soc_timer u_timer (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .avalid_i (tmr_avalid),
      .addr_i   (d_addr_i[`SOC_TMR_AW-1:0]),
      .wdata_i  (d_wdata_i),
      .wstrb_i  (d_wstrb_i),
      .rdata_o  (tmr_rdata),
      .rvalid_o (tmr_rvalid)
   );

endmodule

`default_nettype wire

//--- verification/tb_soc_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module tb_soc_mem_subsys
   import soc_mem_pkg::*;
();

   localparam int n_words = 1 << `SOC_MEM_AW;
   localparam int n_rd = 2000;
   localparam int n_bs = 1500;
   localparam int n_dp = 1500;
   localparam int tmr_run = 40;
   // reset, fill, read, strobe, dual port, timer, final flush
   localparam int run_cycles = 6 + n_words + n_rd + n_bs + n_dp + 5 + 3 * tmr_run + 1;
   localparam int cycle_limit = run_cycles + 100;

   // expected response of one bus for one cycle
   typedef struct packed {
      logic  valid;
      data_t data;
      data_t mask;
   } resp_t;

   logic      clk = 1'b0;
   logic      rst;
   logic      i_avalid;
   mem_addr_t i_addr;
   data_t     i_rdata;
   logic      i_rvalid;
   logic      i_ready;
   logic      d_avalid;
   d_addr_t   d_addr;
   data_t     d_wdata;
   strb_t     d_wstrb;
   data_t     d_rdata;
   logic      d_rvalid;
   logic      d_ready;

   logic [31:0] seed;
   int          cycle_count = 0;

   // memory model with per-byte written flags
   data_t model_mem [0:n_words-1];
   strb_t model_wr [0:n_words-1];

   // timer model
   logic  m_en;
   data_t m_load;
   data_t m_count;

   resp_t i_exp_q[$];
   resp_t d_exp_q[$];

   soc_mem_subsys u_dut (
      .clk_i      (clk),
      .rst_i      (rst),
      .i_avalid_i (i_avalid),
      .i_addr_i   (i_addr),
      .i_rdata_o  (i_rdata),
      .i_rvalid_o (i_rvalid),
      .i_ready_o  (i_ready),
      .d_avalid_i (d_avalid),
      .d_addr_i   (d_addr),
      .d_wdata_i  (d_wdata),
      .d_wstrb_i  (d_wstrb),
      .d_rdata_o  (d_rdata),
      .d_rvalid_o (d_rvalid),
      .d_ready_o  (d_ready)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: the test did not end within %0d cycles", cycle_limit);
         $display("Test FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   // linear congruential generator
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic data_t byte_mask(strb_t s);
      data_t m;
      m = '0;
      for (int b = 0; b < `SOC_STRB_W; b++) begin
         m[8*b +: 8] = {8{s[b]}};
      end
      return m;
   endfunction

   // data bus address in the peripheral window
   function automatic d_addr_t tmr_addr(logic [`SOC_TMR_AW-1:0] off);
      return {1'b1, {(`SOC_D_AW-1-`SOC_TMR_AW){1'b0}}, off};
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("error %s: got %h, expected %h", name, actual, expected);
         $display("Test FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // outputs are stable at the falling edge
   task automatic check_responses();
      resp_t e;
      check_value("i_ready_o", 32'(i_ready), 32'd1);
      check_value("d_ready_o", 32'(d_ready), 32'd1);
      if (i_exp_q.size() > 0) begin
         e = i_exp_q.pop_front();
         check_value("i_rvalid_o", 32'(i_rvalid), 32'(e.valid));
         if (e.valid) begin
            check_value("i_rdata_o", i_rdata & e.mask, e.data & e.mask);
         end
      end
      if (d_exp_q.size() > 0) begin
         e = d_exp_q.pop_front();
         check_value("d_rvalid_o", 32'(d_rvalid), 32'(e.valid));
         if (e.valid) begin
            check_value("d_rdata_o", d_rdata & e.mask, e.data & e.mask);
         end
      end
   endtask

   // one clock cycle, called at the falling edge
   task automatic drive_cycle(input logic i_av, input mem_addr_t i_a, input logic d_av,
                              input d_addr_t d_a, input data_t wd, input strb_t ws);
      resp_t                  ie;
      resp_t                  de;
      mem_addr_t              ma;
      logic [`SOC_TMR_AW-1:0] off;
      logic                   to_tmr;
      logic                   copy;
      logic                   n_en;
      data_t                  n_load;
      check_responses();
      i_avalid = i_av;
      i_addr = i_a;
      d_avalid = d_av;
      d_addr = d_a;
      d_wdata = wd;
      d_wstrb = ws;
      ma = d_a[`SOC_MEM_AW-1:0];
      off = d_a[`SOC_TMR_AW-1:0];
      to_tmr = d_a[`SOC_D_AW-1];

      // responses come from the state before this edge
      ie.valid = i_av;
      ie.data = model_mem[i_a];
      ie.mask = byte_mask(model_wr[i_a]);
      de.valid = d_av && (ws == '0);
      de.data = '0;
      de.mask = '1;
      if (to_tmr) begin
         case (off)
            `SOC_TMR_CTRL:  de.data = data_t'(m_en);
            `SOC_TMR_LOAD:  de.data = m_load;
            `SOC_TMR_COUNT: de.data = m_count;
            default:        de.data = '0;
         endcase
      end else begin
         de.data = model_mem[ma];
         de.mask = byte_mask(model_wr[ma]);
      end
      i_exp_q.push_back(ie);
      d_exp_q.push_back(de);

      if (d_av && !to_tmr) begin
         for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (ws[b]) begin
               model_mem[ma][8*b +: 8] = wd[8*b +: 8];
               model_wr[ma][b] = 1'b1;
            end
         end
      end

      // timer register update at this edge
      n_en = m_en;
      n_load = m_load;
      copy = 1'b0;
      if (d_av && to_tmr && ws != '0) begin
         if (off == `SOC_TMR_LOAD) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
               if (ws[b]) begin
                  n_load[8*b +: 8] = wd[8*b +: 8];
               end
            end
         end
         if (off == `SOC_TMR_CTRL && ws[0]) begin
            n_en = wd[0];
            copy = wd[1];
         end
      end
      if (copy) begin
         m_count = m_load;
      end else if (m_en) begin
         m_count = m_count + 32'd1;
      end
      m_en = n_en;
      m_load = n_load;
      @(negedge clk);
   endtask

   task automatic idle_cycle();
      drive_cycle(1'b0, '0, 1'b0, '0, '0, '0);
   endtask

   // random timer and memory reads, so responses alternate between targets
   task automatic timer_mix(input int n);
      logic [31:0] r;
      int          op;
      for (int k = 0; k < n; k++) begin
         r = next_rand();
         op = int'(r[31:16] % 16'd6);
         case (op)
            0: idle_cycle();
            1: drive_cycle(1'b0, '0, 1'b1, d_addr_t'(r[11:0]), '0, '0);
            2: drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_COUNT), '0, '0);
            3: drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_CTRL), '0, '0);
            4: drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_LOAD), '0, '0);
            default: drive_cycle(1'b0, '0, 1'b1, tmr_addr(2'd3), '0, '0);
         endcase
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] q;
      strb_t       s;
      mem_addr_t   ia;
      mem_addr_t   da;
      seed = 32'd82;
      rst = 1'b1;
      // read requests held during reset, rvalid must stay low
      i_avalid = 1'b1;
      i_addr = '0;
      d_avalid = 1'b1;
      d_addr = '0;
      d_wdata = '0;
      d_wstrb = '0;
      m_en = 1'b0;
      m_load = '0;
      m_count = '0;
      for (int a = 0; a < n_words; a++) begin
         model_wr[a] = '0;
      end

      repeat (5) @(posedge clk);
      @(negedge clk);
      check_value("i_rvalid_o", 32'(i_rvalid), 32'd0);
      check_value("d_rvalid_o", 32'(d_rvalid), 32'd0);
      check_value("i_ready_o", 32'(i_ready), 32'd1);
      check_value("d_ready_o", 32'(d_ready), 32'd1);
      rst = 1'b0;

      // fill every word, writes must not raise rvalid
      for (int a = 0; a < n_words; a++) begin
         drive_cycle(1'b0, '0, 1'b1, d_addr_t'(a), next_rand(), '1);
      end

      // back-to-back data reads with some instruction reads
      for (int k = 0; k < n_rd; k++) begin
         r = next_rand();
         q = next_rand();
         drive_cycle(q[31], mem_addr_t'(q[27:16]), 1'b1, d_addr_t'(r[27:16]), '0, '0);
      end

      // partial strobes on a small window
      for (int k = 0; k < n_bs; k++) begin
         r = next_rand();
         s = r[27:24];
         if (r[31]) begin
            s = '0;
         end
         drive_cycle(1'b0, '0, 1'b1, d_addr_t'(r[20:16]), next_rand(), s);
      end

      // instruction reads against data writes, frequent collisions
      for (int k = 0; k < n_dp; k++) begin
         r = next_rand();
         q = next_rand();
         s = r[27:24];
         if (s == '0) begin
            s = '1;
         end
         da = mem_addr_t'(r[19:16]);
         ia = (k % 4 == 0) ? da : mem_addr_t'(q[19:16]);
         drive_cycle(1'b1, ia, 1'b1, d_addr_t'(da), next_rand(), s);
      end

      // timer: load, copy and enable, then disable and re-enable
      drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_LOAD), next_rand(), '1);
      drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_CTRL), 32'h3, 4'h1);
      timer_mix(tmr_run);
      drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_LOAD), next_rand(), 4'b0101);
      drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_CTRL), 32'h2, 4'h1);
      timer_mix(tmr_run);
      drive_cycle(1'b0, '0, 1'b1, tmr_addr(`SOC_TMR_CTRL), 32'h1, 4'h1);
      timer_mix(tmr_run);

      idle_cycle();
      check_responses();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
logic/soc_mem_pkg.sv
logic/soc_ram_dp_be.sv
logic/soc_int_mem.sv
logic/soc_data_split.sv
logic/soc_timer.sv
logic/soc_mem_subsys.sv
verification/tb_soc_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal \
   -f vlog.f \
   --top-module tb_soc_mem_subsys \
   -o tb_soc_mem_subsys

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_soc_mem_subsys
